// File: Bender.yml
package:
  name: dmi_subsystem

sources:
  - include_dirs:
      - include
    files:
      - rtl/dmi_pkg.sv
      - rtl/dmi_port_select.sv
      - rtl/dm_regs.sv
      - rtl/halt_req_gate.sv
      - rtl/dmi_subsystem.sv
      - target: test
        files:
          - bench/dmi_checker.sv
          - bench/tb_dmi_subsystem.sv

// File: bench/dmi_checker.sv
/*
 * DMI front end checker
 * Models the debug registers, compares every response in order and
 * watches the debug request, dm reset and the idle DTM side
 */
`timescale 1ns/1ns
`default_nettype none
`include "dmi_defines.svh"

module dmi_checker (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  dmi_pkg::dmi_req_t  jtag_req_i,
  input  logic               jtag_req_valid_i,
  input  logic               jtag_req_ready_o,
  input  dmi_pkg::dmi_resp_t jtag_resp_o,
  input  logic               jtag_resp_valid_o,
  input  logic               jtag_resp_ready_i,
  input  logic               dtm_req_ready_o,
  input  dmi_pkg::dmi_resp_t dtm_resp_o,
  input  logic               dtm_resp_valid_o,
  input  logic               debug_req_o,
  input  logic               dm_rst_o,
  output int unsigned        resp_errs_o,
  output int unsigned        level_errs_o,
  output int unsigned        proto_errs_o
);
  import dmi_pkg::*;

  typedef struct packed {
    logic      ctrl_wr;
    dmi_resp_t resp;
  } expect_t;

  expect_t                pending_q[$];
  expect_t                entry;
  logic [`DMI_DATA_W-1:0] data0_m;
  logic [`DMI_DATA_W-1:0] data1_m;
  logic [`DMI_DATA_W-1:0] ctrl_m;
  int unsigned            cyc;
  int unsigned            ctrl_inflight;
  int unsigned            quiet;
  logic                   exp_dbg;
  logic                   exp_rst;

  // Expected response of one request against the model registers
  function automatic dmi_resp_t ref_resp(input dmi_req_t req, input logic [31:0] d0,
                                         input logic [31:0] d1, input logic [31:0] ctrl);
    dmi_resp_t   r;
    logic        mapped;
    logic [31:0] val;
    mapped = 1'b1;
    val    = '0;
    if (req.addr == `DMI_ADDR_DATA0) val = d0;
    else if (req.addr == `DMI_ADDR_DATA1) val = d1;
    else if (req.addr == `DMI_ADDR_DMCONTROL) val = ctrl;
    else if (req.addr == `DMI_ADDR_DMSTATUS) val = `DMSTATUS_VALUE;
    else if (req.addr == `DMI_ADDR_HARTINFO) val = `HARTINFO_VALUE;
    else mapped = 1'b0;
    r.data = '0;
    r.resp = DMI_SUCCESS;
    if (req.op == DMI_READ || req.op == DMI_WRITE) begin
      if (!mapped) r.resp = DMI_FAILED;
      else if (req.op == DMI_READ) r.data = val;
    end else if (req.op != DMI_NOP) begin
      r.resp = DMI_FAILED;
    end
    return r;
  endfunction

  // --------------------------------------------------------------------------
  // Per-cycle comparison, sampled before the edge updates land
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      pending_q.delete();
      data0_m       = '0;
      data1_m       = '0;
      ctrl_m        = '0;
      cyc           = 0;
      ctrl_inflight = 0;
      quiet         = 0;
      resp_errs_o   = 0;
      level_errs_o  = 0;
      proto_errs_o  = 0;
    end else begin
      cyc = cyc + 1;
      if (dtm_req_ready_o !== 1'b0 || dtm_resp_valid_o !== 1'b0 || dtm_resp_o !== '0) begin
        $display("CHECK FAILED at %0t: dtm side ready %b resp valid %b resp %h, expected 0 0 0",
                 $time, dtm_req_ready_o, dtm_resp_valid_o, dtm_resp_o);
        level_errs_o = level_errs_o + 1;
      end
      // Levels only once no dmcontrol write is on its way
      if (ctrl_inflight == 0 && quiet == 0) begin
        exp_dbg = (cyc > `DMI_DEL_CYCLES + 1) && ctrl_m[`DMCTRL_HALTREQ_BIT] &&
                  ctrl_m[`DMCTRL_DMACTIVE_BIT];
        exp_rst = ctrl_m[`DMCTRL_NDMRESET_BIT] && ctrl_m[`DMCTRL_DMACTIVE_BIT];
        if (debug_req_o !== exp_dbg || dm_rst_o !== exp_rst) begin
          $display("CHECK FAILED at %0t: debug_req %b dm_rst %b, expected %b %b",
                   $time, debug_req_o, dm_rst_o, exp_dbg, exp_rst);
          level_errs_o = level_errs_o + 1;
        end
      end
      if (quiet > 0) quiet = quiet - 1;

      if (jtag_resp_valid_o && jtag_resp_ready_i) begin
        if (pending_q.size() == 0) begin
          $display("Response at %0t arrived with no request outstanding", $time);
          proto_errs_o = proto_errs_o + 1;
        end else begin
          entry = pending_q.pop_front();
          if (jtag_resp_o !== entry.resp) begin
            $display("CHECK FAILED at %0t: response %h status %0d, expected %h status %0d",
                     $time, jtag_resp_o.data, jtag_resp_o.resp,
                     entry.resp.data, entry.resp.resp);
            resp_errs_o = resp_errs_o + 1;
          end
          if (entry.ctrl_wr) begin
            ctrl_inflight = ctrl_inflight - 1;
            quiet         = 1;
          end
        end
      end

      if (jtag_req_valid_i && jtag_req_ready_o) begin
        entry.resp    = ref_resp(jtag_req_i, data0_m, data1_m, ctrl_m);
        entry.ctrl_wr = (jtag_req_i.op == DMI_WRITE) &&
                        (jtag_req_i.addr == `DMI_ADDR_DMCONTROL);
        pending_q.push_back(entry);
        if (entry.ctrl_wr) ctrl_inflight = ctrl_inflight + 1;
        if (jtag_req_i.op == DMI_WRITE) begin
          case (jtag_req_i.addr)
            `DMI_ADDR_DATA0:     data0_m = jtag_req_i.data;
            `DMI_ADDR_DATA1:     data1_m = jtag_req_i.data;
            `DMI_ADDR_DMCONTROL: ctrl_m = jtag_req_i.data;
            default:             ;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_dmi_subsystem.sv
/*
 * DMI front end testbench
 * Drives the JTAG-side DMI port with directed and random requests,
 * throttles responses and walks the halt request and ndmreset cases
 */
`timescale 1ns/1ns
`default_nettype none
`include "dmi_defines.svh"

module tb_dmi_subsystem;
  import dmi_pkg::*;

  localparam int unsigned NumTxn     = 62;
  localparam int unsigned BurstLen   = 32;
  localparam int unsigned ClkPeriod  = 20;
  localparam int unsigned RunLimitNs = (`DMI_DEL_CYCLES + 16 * NumTxn + 200) * ClkPeriod;

  logic        clk_i;
  logic        rst_ni;
  dmi_req_t    jtag_req_i;
  logic        jtag_req_valid_i;
  logic        jtag_req_ready_o;
  dmi_resp_t   jtag_resp_o;
  logic        jtag_resp_valid_o;
  logic        jtag_resp_ready_i;
  dmi_req_t    dtm_req_i;
  logic        dtm_req_valid_i;
  logic        dtm_req_ready_o;
  dmi_resp_t   dtm_resp_o;
  logic        dtm_resp_valid_o;
  logic        dtm_resp_ready_i;
  logic        debug_req_o;
  logic        dm_rst_o;
  int unsigned resp_errs;
  int unsigned level_errs;
  int unsigned proto_errs;
  integer      seed = 5808;
  integer      stall_seed;
  logic        stall_en;
  int unsigned stretch;
  int unsigned sent_cnt;
  int unsigned recv_cnt;
  time         rel_time;

  dmi_subsystem #(
    .JtagEnable ( 1'b1 )
  ) dmi_subsystem_inst (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .jtag_req_i        ( jtag_req_i        ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_req_ready_o  ( jtag_req_ready_o  ),
    .jtag_resp_o       ( jtag_resp_o       ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .dtm_req_i         ( dtm_req_i         ),
    .dtm_req_valid_i   ( dtm_req_valid_i   ),
    .dtm_req_ready_o   ( dtm_req_ready_o   ),
    .dtm_resp_o        ( dtm_resp_o        ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
    .debug_req_o       ( debug_req_o       ),
    .dm_rst_o          ( dm_rst_o          )
  );

  dmi_checker dmi_checker_inst (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .jtag_req_i        ( jtag_req_i        ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_req_ready_o  ( jtag_req_ready_o  ),
    .jtag_resp_o       ( jtag_resp_o       ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .dtm_req_ready_o   ( dtm_req_ready_o   ),
    .dtm_resp_o        ( dtm_resp_o        ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .debug_req_o       ( debug_req_o       ),
    .dm_rst_o          ( dm_rst_o          ),
    .resp_errs_o       ( resp_errs         ),
    .level_errs_o      ( level_errs        ),
    .proto_errs_o      ( proto_errs        )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Response back-pressure, random high and low stretches when enabled
  always @(negedge clk_i) begin
    if (!stall_en) begin
      jtag_resp_ready_i = 1'b1;
    end else if (stretch == 0) begin
      stretch           = $random(stall_seed) & 7;
      jtag_resp_ready_i = ~jtag_resp_ready_i;
    end else begin
      stretch = stretch - 1;
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni && jtag_resp_valid_o && jtag_resp_ready_i) recv_cnt <= recv_cnt + 1;
  end

  function automatic dmi_req_t make_req(input logic [6:0] addr, input logic [1:0] op,
                                        input logic [31:0] data);
    dmi_req_t r;
    r.addr = addr;
    r.op   = dmi_op_e'(op);
    r.data = data;
    return r;
  endfunction

  // Called on a falling edge, returns on the falling edge after the handshake
  task automatic send_req(input dmi_req_t req);
    logic taken;
    taken            = 1'b0;
    jtag_req_i       = req;
    jtag_req_valid_i = 1'b1;
    while (!taken) begin
      @(posedge clk_i);
      taken = jtag_req_ready_o;
    end
    sent_cnt = sent_cnt + 1;
    @(negedge clk_i);
    jtag_req_valid_i = 1'b0;
  endtask

  task automatic wait_responses();
    while (recv_cnt != sent_cnt) @(posedge clk_i);
    @(negedge clk_i);
  endtask

  initial begin
    logic [31:0] d0;
    logic [31:0] d1;
    logic [6:0]  addr;
    logic [1:0]  op;
    int          pick;
    rst_ni            = 1'b0;
    jtag_req_i        = '0;
    jtag_req_valid_i  = 1'b0;
    jtag_resp_ready_i = 1'b1;
    // Idle side keeps pushing a data0 write that must never land
    dtm_req_i         = make_req(`DMI_ADDR_DATA0, 2'd2, 32'hdead_beef);
    dtm_req_valid_i   = 1'b1;
    dtm_resp_ready_i  = 1'b1;
    stall_seed        = seed ^ 32'h0000_3c5a;
    stall_en          = 1'b0;
    stretch           = 0;
    sent_cnt          = 0;
    recv_cnt          = 0;
    repeat (4) @(negedge clk_i);
    rst_ni   = 1'b1;
    rel_time = $time;

    // Halt request while the boot window is still open
    send_req(make_req(`DMI_ADDR_DMCONTROL, 2'd2, 32'h8000_0001));
    for (int i = 0; i < 4; i++) begin
      d0 = $random(seed);
      d1 = $random(seed);
      send_req(make_req(`DMI_ADDR_DATA0, 2'd2, d0));
      send_req(make_req(`DMI_ADDR_DATA1, 2'd2, d1));
      send_req(make_req(`DMI_ADDR_DATA0, 2'd1, '0));
      send_req(make_req(`DMI_ADDR_DATA1, 2'd1, '0));
    end
    send_req(make_req(`DMI_ADDR_DATA0, 2'd0, 32'h1234_5678));

    // Read-only registers
    send_req(make_req(`DMI_ADDR_DMSTATUS, 2'd1, '0));
    send_req(make_req(`DMI_ADDR_HARTINFO, 2'd1, '0));
    send_req(make_req(`DMI_ADDR_DMSTATUS, 2'd2, 32'hffff_ffff));
    send_req(make_req(`DMI_ADDR_HARTINFO, 2'd2, 32'hffff_ffff));
    send_req(make_req(`DMI_ADDR_DMSTATUS, 2'd1, '0));
    send_req(make_req(`DMI_ADDR_HARTINFO, 2'd1, '0));

    // Unmapped addresses and the reserved op
    send_req(make_req(7'h20, 2'd1, '0));
    send_req(make_req(7'h7f, 2'd2, 32'h5555_aaaa));
    send_req(make_req(`DMI_ADDR_DATA0, 2'd3, 32'h0bad_0bad));
    send_req(make_req(`DMI_ADDR_DATA0, 2'd1, '0));
    wait_responses();

    // ------------------------------------------------------------------------
    // Random burst under response back-pressure
    // ------------------------------------------------------------------------
    stall_en = 1'b1;
    for (int i = 0; i < BurstLen; i++) begin
      pick = $random(seed) & 7;
      case (pick)
        0:       addr = `DMI_ADDR_DATA0;
        1:       addr = `DMI_ADDR_DATA1;
        2:       addr = `DMI_ADDR_DMSTATUS;
        3:       addr = `DMI_ADDR_HARTINFO;
        4:       addr = `DMI_ADDR_DMCONTROL;
        default: addr = $random(seed);
      endcase
      op = $random(seed);
      // dmcontrol stays untouched during the burst
      if (addr == `DMI_ADDR_DMCONTROL && op == 2'd2) op = 2'd1;
      send_req(make_req(addr, op, $random(seed)));
    end
    wait_responses();
    stall_en = 1'b0;

    // Past the boot window, then ndmreset on and everything off
    while ($time < rel_time + (`DMI_DEL_CYCLES + 10) * ClkPeriod) @(negedge clk_i);
    send_req(make_req(`DMI_ADDR_DMCONTROL, 2'd2, 32'h8000_0003));
    wait_responses();
    repeat (4) @(negedge clk_i);
    send_req(make_req(`DMI_ADDR_DMCONTROL, 2'd2, 32'h0000_0000));
    wait_responses();
    repeat (4) @(negedge clk_i);

    $display("Errors: response %0d, level %0d, protocol %0d", resp_errs, level_errs,
             proto_errs);
    if (resp_errs + level_errs + proto_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(RunLimitNs);
    $display("Timeout: the run did not complete within %0d ns", RunLimitNs);
    $display("Errors: response %0d, level %0d, protocol %0d", resp_errs, level_errs,
             proto_errs);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dmi_subsystem.f
+incdir+include
rtl/dmi_pkg.sv
rtl/dmi_port_select.sv
rtl/dm_regs.sv
rtl/halt_req_gate.sv
rtl/dmi_subsystem.sv
bench/dmi_checker.sv
bench/tb_dmi_subsystem.sv

// File: include/dmi_defines.svh
/*
 * DMI debug front end constants
 * Bus widths, debug register addresses, dmcontrol bit positions,
 * read-only register values and the post-reset debug request delay
 */
`ifndef DMI_DEFINES_SVH
`define DMI_DEFINES_SVH

// Bus widths
`define DMI_ADDR_W 7
`define DMI_DATA_W 32

// Boot window before a debug request may reach the core
`define DMI_DEL_CYCLES 500

// Debug register map
`define DMI_ADDR_DATA0     7'h04
`define DMI_ADDR_DATA1     7'h05
`define DMI_ADDR_DMCONTROL 7'h10
`define DMI_ADDR_DMSTATUS  7'h11
`define DMI_ADDR_HARTINFO  7'h12

// dmcontrol fields
`define DMCTRL_DMACTIVE_BIT 0
`define DMCTRL_NDMRESET_BIT 1
`define DMCTRL_HALTREQ_BIT  31

// Version 2 in [3:0], authenticated in [7]
`define DMSTATUS_VALUE 32'h0000_0082
// nscratch 2, dataaccess 1, datasize 2, dataaddr 0x380
`define HARTINFO_VALUE 32'h0021_2380

`endif

// File: rtl/dm_regs.sv
/*
 * Debug register target
 * Executes DMI reads and writes on data0, data1 and dmcontrol,
 * serves the read-only dmstatus and hartinfo, holds one response
 */
`timescale 1ns/1ns
`default_nettype none
`include "dmi_defines.svh"

module dm_regs (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  dmi_pkg::dmi_req_t   req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  output dmi_pkg::dmi_resp_t  resp_o,
  output logic                resp_valid_o,
  input  logic                resp_ready_i,
  output logic                dmactive_o,
  output logic                haltreq_o,
  output logic                ndmreset_o
);
  import dmi_pkg::*;

  logic [`DMI_DATA_W-1:0] data0_q;
  logic [`DMI_DATA_W-1:0] data1_q;
  logic [`DMI_DATA_W-1:0] dmcontrol_q;
  logic [`DMI_DATA_W-1:0] rd_data;
  logic                   addr_hit;
  logic                   req_accept;
  logic                   wr_en;
  logic                   exec_q;
  logic                   resp_valid_q;
  dmi_resp_t              resp_d;
  dmi_resp_t              resp_q;

  // --------------------------------------------------------------------------
  // Address decode and response build
  // --------------------------------------------------------------------------
  always_comb begin
    rd_data  = '0;
    addr_hit = 1'b1;
    case (req_i.addr)
      `DMI_ADDR_DATA0:     rd_data = data0_q;
      `DMI_ADDR_DATA1:     rd_data = data1_q;
      `DMI_ADDR_DMCONTROL: rd_data = dmcontrol_q;
      `DMI_ADDR_DMSTATUS:  rd_data = `DMSTATUS_VALUE;
      `DMI_ADDR_HARTINFO:  rd_data = `HARTINFO_VALUE;
      default:             addr_hit = 1'b0;
    endcase
  end

  always_comb begin
    resp_d = '{data: '0, resp: DMI_FAILED};
    case (req_i.op)
      DMI_NOP: resp_d = '{data: '0, resp: DMI_SUCCESS};
      DMI_READ: begin
        if (addr_hit) begin
          resp_d = '{data: rd_data, resp: DMI_SUCCESS};
        end
      end
      DMI_WRITE: begin
        if (addr_hit) begin
          resp_d = '{data: '0, resp: DMI_SUCCESS};
        end
      end
      default: resp_d = '{data: '0, resp: DMI_FAILED};
    endcase
  end

  // Take a new request when the slot is free or drains on this edge
  assign req_ready_o = ~exec_q & (~resp_valid_q | resp_ready_i);
  assign req_accept  = req_valid_i & req_ready_o;
  assign wr_en       = req_accept & (req_i.op == DMI_WRITE);

  // --------------------------------------------------------------------------
  // Debug registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data0_q     <= '0;
      data1_q     <= '0;
      dmcontrol_q <= '0;
    end else if (wr_en) begin
      // dmstatus and hartinfo writes fall through
      case (req_i.addr)
        `DMI_ADDR_DATA0:     data0_q <= req_i.data;
        `DMI_ADDR_DATA1:     data1_q <= req_i.data;
        `DMI_ADDR_DMCONTROL: dmcontrol_q <= req_i.data;
        default:             ;
      endcase
    end
  end

  // Response slot, visible one edge after acceptance
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exec_q       <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      exec_q <= req_accept;
      if (exec_q) begin
        resp_valid_q <= 1'b1;
      end else if (resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      resp_q <= resp_d;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  assign dmactive_o = dmcontrol_q[`DMCTRL_DMACTIVE_BIT];
  assign haltreq_o  = dmcontrol_q[`DMCTRL_HALTREQ_BIT];
  assign ndmreset_o = dmcontrol_q[`DMCTRL_NDMRESET_BIT];

endmodule

`default_nettype wire

// File: rtl/dmi_pkg.sv
/*
 * DMI types
 * Request and response payloads and the op and status encodings
 * shared by both request sources and the debug register target
 */
`default_nettype none
`include "dmi_defines.svh"

package dmi_pkg;

  // Request op, value 3 is reserved
  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2
  } dmi_op_e;

  // Response status
  typedef enum logic [1:0] {
    DMI_SUCCESS = 2'd0,
    DMI_FAILED  = 2'd2
  } dmi_resp_e;

  typedef struct packed {
    logic [`DMI_ADDR_W-1:0] addr;
    dmi_op_e                op;
    logic [`DMI_DATA_W-1:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [`DMI_DATA_W-1:0] data;
    dmi_resp_e              resp;
  } dmi_resp_t;

endpackage

`default_nettype wire

// File: rtl/dmi_port_select.sv
/*
 * DMI source select
 * Takes requests from the JTAG side or the simulation DTM side,
 * buffers one request and returns responses to the live side only
 */
`timescale 1ns/1ns
`default_nettype none
`include "dmi_defines.svh"

module dmi_port_select #(
  parameter bit JtagEnable = 1'b1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // JTAG side
  input  dmi_pkg::dmi_req_t   jtag_req_i,
  input  logic                jtag_req_valid_i,
  output logic                jtag_req_ready_o,
  output dmi_pkg::dmi_resp_t  jtag_resp_o,
  output logic                jtag_resp_valid_o,
  input  logic                jtag_resp_ready_i,
  // Simulation DTM side
  input  dmi_pkg::dmi_req_t   dtm_req_i,
  input  logic                dtm_req_valid_i,
  output logic                dtm_req_ready_o,
  output dmi_pkg::dmi_resp_t  dtm_resp_o,
  output logic                dtm_resp_valid_o,
  input  logic                dtm_resp_ready_i,
  // Toward the register target
  output dmi_pkg::dmi_req_t   req_o,
  output logic                req_valid_o,
  input  logic                req_ready_i,
  input  dmi_pkg::dmi_resp_t  resp_i,
  input  logic                resp_valid_i,
  output logic                resp_ready_o
);
  import dmi_pkg::*;

  dmi_req_t sel_req;
  logic     sel_valid;
  logic     full_q;
  dmi_req_t buf_q;

  // Live source mux
  assign sel_req   = JtagEnable ? jtag_req_i : dtm_req_i;
  assign sel_valid = JtagEnable ? jtag_req_valid_i : dtm_req_valid_i;

  // Source ready only while the holding register is empty
  assign jtag_req_ready_o = JtagEnable ? ~full_q : 1'b0;
  assign dtm_req_ready_o  = JtagEnable ? 1'b0 : ~full_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      full_q <= ~req_ready_i;
    end else begin
      full_q <= sel_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!full_q && sel_valid) begin
      buf_q <= sel_req;
    end
  end

  assign req_o       = buf_q;
  assign req_valid_o = full_q;

  // Response steering, the idle side sees nothing
  assign jtag_resp_o       = JtagEnable ? resp_i : '0;
  assign jtag_resp_valid_o = JtagEnable ? resp_valid_i : 1'b0;
  assign dtm_resp_o        = JtagEnable ? '0 : resp_i;
  assign dtm_resp_valid_o  = JtagEnable ? 1'b0 : resp_valid_i;
  assign resp_ready_o      = JtagEnable ? jtag_resp_ready_i : dtm_resp_ready_i;

endmodule

`default_nettype wire

// File: rtl/dmi_subsystem.sv
/*
 * DMI debug front end
 * Source select, debug register target and debug request gating
 */
`timescale 1ns/1ns
`default_nettype none
`include "dmi_defines.svh"

module dmi_subsystem #(
  parameter bit JtagEnable = 1'b1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // JTAG side
  input  dmi_pkg::dmi_req_t   jtag_req_i,
  input  logic                jtag_req_valid_i,
  output logic                jtag_req_ready_o,
  output dmi_pkg::dmi_resp_t  jtag_resp_o,
  output logic                jtag_resp_valid_o,
  input  logic                jtag_resp_ready_i,
  // Simulation DTM side
  input  dmi_pkg::dmi_req_t   dtm_req_i,
  input  logic                dtm_req_valid_i,
  output logic                dtm_req_ready_o,
  output dmi_pkg::dmi_resp_t  dtm_resp_o,
  output logic                dtm_resp_valid_o,
  input  logic                dtm_resp_ready_i,
  // Core side
  output logic                debug_req_o,
  output logic                dm_rst_o
);
  import dmi_pkg::*;

  dmi_req_t  dmi_req;
  logic      dmi_req_valid;
  logic      dmi_req_ready;
  dmi_resp_t dmi_resp;
  logic      dmi_resp_valid;
  logic      dmi_resp_ready;
  logic      dmactive;
  logic      haltreq;
  logic      ndmreset;

  dmi_port_select #(
    .JtagEnable ( JtagEnable )
  ) i_dmi_port_select (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .jtag_req_i        ( jtag_req_i        ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_req_ready_o  ( jtag_req_ready_o  ),
    .jtag_resp_o       ( jtag_resp_o       ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .dtm_req_i         ( dtm_req_i         ),
    .dtm_req_valid_i   ( dtm_req_valid_i   ),
    .dtm_req_ready_o   ( dtm_req_ready_o   ),
    .dtm_resp_o        ( dtm_resp_o        ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
    .req_o             ( dmi_req           ),
    .req_valid_o       ( dmi_req_valid     ),
    .req_ready_i       ( dmi_req_ready     ),
    .resp_i            ( dmi_resp          ),
    .resp_valid_i      ( dmi_resp_valid    ),
    .resp_ready_o      ( dmi_resp_ready    )
  );

  dm_regs i_dm_regs (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .req_i        ( dmi_req        ),
    .req_valid_i  ( dmi_req_valid  ),
    .req_ready_o  ( dmi_req_ready  ),
    .resp_o       ( dmi_resp       ),
    .resp_valid_o ( dmi_resp_valid ),
    .resp_ready_i ( dmi_resp_ready ),
    .dmactive_o   ( dmactive       ),
    .haltreq_o    ( haltreq        ),
    .ndmreset_o   ( ndmreset       )
  );

  halt_req_gate i_halt_req_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .dmactive_i  ( dmactive    ),
    .haltreq_i   ( haltreq     ),
    .ndmreset_i  ( ndmreset    ),
    .debug_req_o ( debug_req_o ),
    .dm_rst_o    ( dm_rst_o    )
  );

endmodule

`default_nettype wire

// File: rtl/halt_req_gate.sv
/*
 * Debug request gate
 * Holds off the core debug request for a boot window after reset
 * and qualifies halt request and ndmreset with dmactive
 */
`timescale 1ns/1ns
`default_nettype none
`include "dmi_defines.svh"

module halt_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic dmactive_i,
  input  logic haltreq_i,
  input  logic ndmreset_i,
  output logic debug_req_o,
  output logic dm_rst_o
);

  localparam int unsigned CntW = $clog2(`DMI_DEL_CYCLES + 1);

  logic [CntW-1:0] del_cnt_q;
  logic            del_done;

  assign del_done = (del_cnt_q == '0);

  // Boot window counter, stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q   <= CntW'(`DMI_DEL_CYCLES);
      debug_req_o <= 1'b0;
      dm_rst_o    <= 1'b0;
    end else begin
      if (!del_done) begin
        del_cnt_q <= del_cnt_q - 1'b1;
      end
      debug_req_o <= del_done & haltreq_i & dmactive_i;
      dm_rst_o    <= ndmreset_i & dmactive_i;
    end
  end

endmodule

`default_nettype wire
